/* flist.f */
+incdir+include
hw/ex_pkg.sv
hw/stage_reg.sv
hw/id_ex_regs.sv
hw/int_alu.sv
hw/ex_result_unit.sv
hw/ex_stage.sv
verification/ex_stage_tb.sv

/* include/ex_tb_model.svh */
`ifndef EX_TB_MODEL_SVH
`define EX_TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference ALU
////////////////////////////////////////////////////////////////////////////

// Compare outcome in bit 0, zeros above
function automatic logic [ex_pkg::XLEN-1:0] flag_word(input logic flag);
    return {{(ex_pkg::XLEN-1){1'b0}}, flag};
endfunction

function automatic logic [ex_pkg::XLEN-1:0] model_alu(
    input ex_pkg::alu_op_t         op,
    input logic [ex_pkg::XLEN-1:0] a,
    input logic [ex_pkg::XLEN-1:0] b
);
    logic [ex_pkg::XLEN-1:0] sign_bit;
    logic [ex_pkg::XLEN-1:0] ones;
    logic [ex_pkg::XLEN-1:0] fill;
    logic [4:0]              sh;
    logic                    lt_s;
    logic                    lt_u;
    sign_bit = {1'b1, {(ex_pkg::XLEN-1){1'b0}}};
    ones     = '1;
    sh       = b[4:0];
    // Signed order is the unsigned order with both sign bits flipped
    lt_s     = (a ^ sign_bit) < (b ^ sign_bit);
    lt_u     = a < b;
    // Ones brought in from the top by an arithmetic shift
    fill     = a[ex_pkg::XLEN-1] ? ~(ones >> sh) : '0;
    case (op)
        ex_pkg::ALU_ADD:  return a + b;
        ex_pkg::ALU_SUB:  return a + ~b + 1'b1;
        ex_pkg::ALU_AND:  return a & b;
        ex_pkg::ALU_OR:   return a | b;
        ex_pkg::ALU_XOR:  return a ^ b;
        ex_pkg::ALU_SLL:  return a << sh;
        ex_pkg::ALU_SRL:  return a >> sh;
        ex_pkg::ALU_SRA:  return (a >> sh) | fill;
        ex_pkg::ALU_SLT:  return flag_word(lt_s);
        ex_pkg::ALU_LT:   return flag_word(lt_s);
        ex_pkg::ALU_SLTU: return flag_word(lt_u);
        ex_pkg::ALU_EQ:   return flag_word(a == b);
        ex_pkg::ALU_NE:   return flag_word(a != b);
        ex_pkg::ALU_GE:   return flag_word(!lt_s);
        ex_pkg::ALU_GEU:  return flag_word(!lt_u);
        default:          return '0;
    endcase
endfunction

////////////////////////////////////////////////////////////////////////////
// Expected stage outputs
////////////////////////////////////////////////////////////////////////////

// CSR read data overrides the ALU, fresh in the first cycle only
function automatic logic [ex_pkg::XLEN-1:0] expected_result(
    input ex_pkg::ex_ctrl_t        ctrl,
    input ex_pkg::ex_data_t        data,
    input logic                    first_cycle,
    input logic [ex_pkg::XLEN-1:0] rdata,
    input logic [ex_pkg::XLEN-1:0] held
);
    if (ctrl.csr_access) begin
        return first_cycle ? rdata : held;
    end
    return model_alu(data.alu_op, data.operand_1, data.operand_2);
endfunction

function automatic ex_pkg::ex_mem_t expected_mem(
    input ex_pkg::ex_ctrl_t        ctrl,
    input ex_pkg::ex_data_t        data,
    input logic [ex_pkg::XLEN-1:0] result
);
    ex_pkg::ex_mem_t m;
    m.rd_addr     = ctrl.rd_addr;
    m.rd_bank     = ctrl.rd_bank;
    m.result      = result;
    m.mem_req     = ctrl.mem_req;
    m.mem_wen     = ctrl.mem_wen;
    m.mem_type    = ctrl.mem_type;
    m.mem_sext    = ctrl.mem_sext;
    m.mem_wdata   = data.mem_wdata;
    m.reg_alu_wen = ctrl.reg_alu_wen;
    m.reg_mem_wen = ctrl.reg_mem_wen;
    m.valid       = ctrl.valid;
    return m;
endfunction

// Misaligned taken target traps, compressed ISA is off here
function automatic logic expected_trap(
    input ex_pkg::ex_ctrl_t        ctrl,
    input logic                    taken,
    input logic [ex_pkg::XLEN-1:0] target
);
    return ctrl.valid && taken && target[1];
endfunction

`endif

/* verification/ex_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_stage_tb;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 2000;
    // Whole run plus a few spare cycles
    localparam int TIMEOUT      = (NUM_TESTS + RESET_CYCLES + 10) * PERIOD;

    logic                    clk_i;
    logic                    rst_n_i;
    ex_pkg::ex_ctrl_t        id_ctrl_i;
    ex_pkg::ex_data_t        id_data_i;
    logic [ex_pkg::XLEN-1:0] csr_rdata_i;
    logic                    stall_i;
    logic                    flush_i;
    ex_pkg::ex_mem_t         mem_o;
    ex_pkg::csr_req_t        csr_req_o;
    ex_pkg::csr_op_t         csr_op_o;
    logic                    csr_access_o;
    logic [ex_pkg::XLEN-1:0] pc_o;
    ex_pkg::pc_source_t      pc_source_o;
    logic [ex_pkg::XLEN-1:0] branch_target_o;
    logic                    branch_taken_o;
    logic                    trap_o;

    integer seed;

    // Model of the stage registers
    ex_pkg::ex_ctrl_t        m_ctrl;
    ex_pkg::ex_data_t        m_data;
    ex_pkg::csr_req_t        m_csr;
    logic                    m_first;
    logic [ex_pkg::XLEN-1:0] m_held;
    // What happened at the last rising edge
    logic                    edge_stall;
    logic                    edge_flush;
    // Outputs seen at the previous check
    logic [255:0]            prev_snap;
    logic [ex_pkg::XLEN-1:0] prev_pc;
    logic [ex_pkg::XLEN-1:0] prev_target;
    logic [ex_pkg::XLEN-1:0] prev_wdata;

    `include "ex_tb_model.svh"

    ex_stage #(
        .ISA_C (1'b0),
        .WIDTH (ex_pkg::XLEN)
    ) DUT (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .id_ctrl_i       (id_ctrl_i),
        .id_data_i       (id_data_i),
        .csr_rdata_i     (csr_rdata_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .mem_o           (mem_o),
        .csr_req_o       (csr_req_o),
        .csr_op_o        (csr_op_o),
        .csr_access_o    (csr_access_o),
        .pc_o            (pc_o),
        .pc_source_o     (pc_source_o),
        .branch_target_o (branch_target_o),
        .branch_taken_o  (branch_taken_o),
        .trap_o          (trap_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD/2) clk_i = ~clk_i;
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("Timeout: the stage test did not finish within %0d ns", TIMEOUT);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic compare_field(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
        assert (got === exp) else
            report_error($sformatf("%s is %0h, expected %0h", name, got, exp));
    endtask

    // Every output of the stage in one vector
    function automatic logic [255:0] output_snapshot();
        return {mem_o, csr_req_o, csr_op_o, csr_access_o, pc_o, pc_source_o,
                branch_target_o, branch_taken_o, trap_o};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and model
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_random();
        logic [31:0] ctrl_bits;
        ctrl_bits            = $random(seed);
        id_ctrl_i            = ctrl_bits[$bits(ex_pkg::ex_ctrl_t)-1:0];
        id_ctrl_i.valid      = ($random(seed) & 3) != 0;
        id_ctrl_i.csr_access = ($random(seed) & 3) == 0;
        id_data_i.alu_op     = ex_pkg::alu_op_t'($unsigned($random(seed)) % 15);
        id_data_i.operand_1  = $random(seed);
        // Equal operands now and then so EQ and GE see both outcomes
        id_data_i.operand_2  = (($random(seed) & 3) == 0) ? id_data_i.operand_1
                                                            : $random(seed);
        id_data_i.mem_wdata     = $random(seed);
        id_data_i.pc            = $random(seed);
        id_data_i.branch_target = $random(seed);
        csr_rdata_i = $random(seed);
        stall_i     = ($random(seed) & 7) == 0;
        flush_i     = ($random(seed) & 7) == 0;
    endtask

    // One rising edge of the stage registers
    task automatic update_model();
        edge_stall = stall_i;
        edge_flush = flush_i;
        if (m_first) begin
            m_held = csr_rdata_i;
        end
        if (stall_i) begin
            m_first = 1'b0;
        end else begin
            m_first = id_ctrl_i.csr_access;
            if (flush_i) begin
                m_ctrl = ex_pkg::EX_CTRL_IDLE;
            end else begin
                m_ctrl = id_ctrl_i;
                m_data = id_data_i;
                if (id_ctrl_i.csr_access) begin
                    m_csr.addr  = id_data_i.operand_2[ex_pkg::CSR_ADDR_W-1:0];
                    m_csr.wdata = id_data_i.operand_1;
                end
            end
        end
    endtask

    task automatic check_outputs();
        logic [ex_pkg::XLEN-1:0] exp_res;
        logic                    exp_taken;
        exp_res   = expected_result(m_ctrl, m_data, m_first, csr_rdata_i, m_held);
        exp_taken = m_ctrl.is_branch && exp_res[0];
        compare_field("mem_o", mem_o, expected_mem(m_ctrl, m_data, exp_res));
        compare_field("csr_req_o", csr_req_o, m_csr);
        compare_field("csr_op_o", csr_op_o, m_ctrl.csr_op);
        compare_field("csr_access_o", csr_access_o, m_ctrl.csr_access);
        compare_field("pc_o", pc_o, m_data.pc);
        compare_field("pc_source_o", pc_source_o, m_ctrl.pc_source);
        compare_field("branch_target_o", branch_target_o, m_data.branch_target);
        compare_field("branch_taken_o", branch_taken_o, exp_taken);
        compare_field("trap_o", trap_o,
                      expected_trap(m_ctrl, exp_taken, m_data.branch_target));
        // Nothing may move across a stalled edge
        if (edge_stall) begin
            assert (output_snapshot() === prev_snap) else
                report_error("outputs changed across a stalled edge");
        end
        // A flush bubbles the control and leaves the data fields alone
        if (edge_flush && !edge_stall) begin
            assert (!mem_o.valid && !mem_o.mem_req && !mem_o.mem_wen &&
                    !mem_o.reg_alu_wen && !mem_o.reg_mem_wen && !csr_access_o &&
                    !branch_taken_o && !trap_o) else
                report_error("flush left an enable or valid set");
            assert (pc_o === prev_pc && branch_target_o === prev_target &&
                    mem_o.mem_wdata === prev_wdata) else
                report_error("flush changed the data fields");
        end
        prev_snap   = output_snapshot();
        prev_pc     = pc_o;
        prev_target = branch_target_o;
        prev_wdata  = mem_o.mem_wdata;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        int test_idx;
        seed        = 32'h8200_851e;
        rst_n_i     = 1'b0;
        stall_i     = 1'b0;
        flush_i     = 1'b0;
        id_ctrl_i   = ex_pkg::EX_CTRL_IDLE;
        id_data_i   = '0;
        csr_rdata_i = '0;
        m_ctrl      = ex_pkg::EX_CTRL_IDLE;
        m_data      = '0;
        m_csr       = '0;
        m_first     = 1'b0;
        m_held      = '0;
        edge_stall  = 1'b0;
        edge_flush  = 1'b0;
        // Reset values sampled late in the reset phase
        repeat (RESET_CYCLES - 1) @(negedge clk_i);
        #(PERIOD/4);
        compare_field("reset valid", mem_o.valid, 1'b0);
        compare_field("reset enables", {mem_o.mem_req, mem_o.mem_wen,
                      mem_o.reg_alu_wen, mem_o.reg_mem_wen, csr_access_o}, 5'b0);
        compare_field("reset branch_taken_o", branch_taken_o, 1'b0);
        compare_field("reset trap_o", trap_o, 1'b0);
        compare_field("reset pc_source_o", pc_source_o, ex_pkg::PC_NEXT);
        compare_field("reset csr_op_o", csr_op_o, ex_pkg::CSR_READ);
        check_outputs();
        @(negedge clk_i);
        rst_n_i = 1'b1;
        // Drive on the falling edge and check mid low phase where all is settled
        for (test_idx = 0; test_idx < NUM_TESTS; test_idx++) begin
            drive_random();
            #(PERIOD/4);
            check_outputs();
            @(posedge clk_i);
            update_model();
            @(negedge clk_i);
        end
        #(PERIOD/4);
        check_outputs();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/ex_stage.sv */
`timescale 1ns/10ps
`default_nettype none

// Execute stage top level
module ex_stage #(
    parameter bit ISA_C = 0,
    parameter int WIDTH = ex_pkg::XLEN
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    // From decode
    input  wire ex_pkg::ex_ctrl_t        id_ctrl_i,
    input  wire ex_pkg::ex_data_t        id_data_i,
    // From CSR file
    input  wire logic [ex_pkg::XLEN-1:0] csr_rdata_i,
    // From controller
    input  wire logic                    stall_i,
    input  wire logic                    flush_i,
    // To memory stage
    output ex_pkg::ex_mem_t              mem_o,
    // To CSR file
    output ex_pkg::csr_req_t             csr_req_o,
    output ex_pkg::csr_op_t              csr_op_o,
    output logic                         csr_access_o,
    output logic [ex_pkg::XLEN-1:0]      pc_o,
    // To fetch
    output ex_pkg::pc_source_t           pc_source_o,
    output logic [ex_pkg::XLEN-1:0]      branch_target_o,
    output logic                         branch_taken_o,
    output logic                         trap_o
);

    ex_pkg::ex_ctrl_t        ex_ctrl;
    ex_pkg::ex_data_t        ex_data;
    logic                    csr_first_cycle;
    logic [WIDTH-1:0]        alu_result;
    logic [ex_pkg::XLEN-1:0] result;

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    id_ex_regs u_id_ex_regs (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .flush_i           (flush_i),
        .id_ctrl_i         (id_ctrl_i),
        .id_data_i         (id_data_i),
        .ex_ctrl_o         (ex_ctrl),
        .ex_data_o         (ex_data),
        .csr_req_o         (csr_req_o),
        .csr_first_cycle_o (csr_first_cycle)
    );

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    int_alu #(
        .WIDTH (WIDTH)
    ) u_int_alu (
        .op_i  (ex_data.alu_op),
        .op1_i (ex_data.operand_1),
        .op2_i (ex_data.operand_2),
        .res_o (alu_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Output side
    ////////////////////////////////////////////////////////////////////////////

    ex_result_unit #(
        .ISA_C (ISA_C)
    ) u_ex_result_unit (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .ctrl_i            (ex_ctrl),
        .alu_result_i      (alu_result),
        .branch_target_i   (ex_data.branch_target),
        .csr_first_cycle_i (csr_first_cycle),
        .csr_rdata_i       (csr_rdata_i),
        .result_o          (result),
        .branch_taken_o    (branch_taken_o),
        .trap_o            (trap_o)
    );

    // MEM bundle
    assign mem_o.rd_addr     = ex_ctrl.rd_addr;
    assign mem_o.rd_bank     = ex_ctrl.rd_bank;
    assign mem_o.result      = result;
    assign mem_o.mem_req     = ex_ctrl.mem_req;
    assign mem_o.mem_wen     = ex_ctrl.mem_wen;
    assign mem_o.mem_type    = ex_ctrl.mem_type;
    assign mem_o.mem_sext    = ex_ctrl.mem_sext;
    assign mem_o.mem_wdata   = ex_data.mem_wdata;
    assign mem_o.reg_alu_wen = ex_ctrl.reg_alu_wen;
    assign mem_o.reg_mem_wen = ex_ctrl.reg_mem_wen;
    assign mem_o.valid       = ex_ctrl.valid;

    // CSR side and fetch side
    assign csr_op_o        = ex_ctrl.csr_op;
    assign csr_access_o    = ex_ctrl.csr_access;
    assign pc_o            = ex_data.pc;
    assign pc_source_o     = ex_ctrl.pc_source;
    assign branch_target_o = ex_data.branch_target;

endmodule

`default_nettype wire

/* hw/ex_result_unit.sv */
`timescale 1ns/10ps
`default_nettype none

// Result select, CSR read hold, branch decision and trap
module ex_result_unit #(
    parameter bit ISA_C = 0
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  wire ex_pkg::ex_ctrl_t        ctrl_i,
    input  wire logic [ex_pkg::XLEN-1:0] alu_result_i,
    input  wire logic [ex_pkg::XLEN-1:0] branch_target_i,
    input  wire logic                    csr_first_cycle_i,
    input  wire logic [ex_pkg::XLEN-1:0] csr_rdata_i,
    output logic [ex_pkg::XLEN-1:0]      result_o,
    output logic                         branch_taken_o,
    output logic                         trap_o
);

    logic [ex_pkg::XLEN-1:0] held_rdata;
    logic                    misaligned;

    ////////////////////////////////////////////////////////////////////////////
    // CSR read data
    ////////////////////////////////////////////////////////////////////////////

    // Keep rdata seen in the first cycle, CSR file may move on during a stall
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            held_rdata <= '0;
        end else if (csr_first_cycle_i) begin
            held_rdata <= csr_rdata_i;
        end
    end

    // CSR reads replace the ALU result
    always_comb begin
        if (ctrl_i.csr_access) begin
            if (csr_first_cycle_i) begin
                result_o = csr_rdata_i;
            end else begin
                result_o = held_rdata;
            end
        end else begin
            result_o = alu_result_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////////////////////////////

    // Compare outcome sits in bit 0
    assign branch_taken_o = ctrl_i.is_branch && result_o[0];

    // Without compressed ISA a taken target must be word aligned
    always_comb begin
        if (ISA_C) begin
            misaligned = 1'b0;
        end else begin
            misaligned = branch_taken_o && branch_target_i[1];
        end
    end

    // Only real instructions trap
    assign trap_o = ctrl_i.valid && misaligned;

endmodule

`default_nettype wire

/* hw/int_alu.sv */
`timescale 1ns/10ps
`default_nettype none

// Purely combinational integer ALU
module int_alu #(
    parameter int WIDTH = 32
) (
    input  wire ex_pkg::alu_op_t op_i,
    input  wire logic [WIDTH-1:0] op1_i,
    input  wire logic [WIDTH-1:0] op2_i,
    output logic [WIDTH-1:0]      res_o
);

    // Shift amount taken from the low bits of op2 (5 bits on RV32)
    localparam int SHAMT_W = $clog2(WIDTH);

    logic [SHAMT_W-1:0] shamt;
    logic               cmp;

    assign shamt = op2_i[SHAMT_W-1:0];

    // Compare outcome, zero for every other op
    always_comb begin
        case (op_i)
            ex_pkg::ALU_SLT:  cmp = $signed(op1_i) < $signed(op2_i);
            ex_pkg::ALU_LT:   cmp = $signed(op1_i) < $signed(op2_i);
            ex_pkg::ALU_SLTU: cmp = op1_i < op2_i;
            ex_pkg::ALU_EQ:   cmp = op1_i == op2_i;
            ex_pkg::ALU_NE:   cmp = op1_i != op2_i;
            ex_pkg::ALU_GE:   cmp = $signed(op1_i) >= $signed(op2_i);
            ex_pkg::ALU_GEU:  cmp = op1_i >= op2_i;
            default:          cmp = 1'b0;
        endcase
    end

    always_comb begin
        case (op_i)
            ex_pkg::ALU_ADD: res_o = op1_i + op2_i;
            ex_pkg::ALU_SUB: res_o = op1_i - op2_i;
            ex_pkg::ALU_AND: res_o = op1_i & op2_i;
            ex_pkg::ALU_OR:  res_o = op1_i | op2_i;
            ex_pkg::ALU_XOR: res_o = op1_i ^ op2_i;
            ex_pkg::ALU_SLL: res_o = op1_i << shamt;
            ex_pkg::ALU_SRL: res_o = op1_i >> shamt;
            // Arithmetic shift keeps the sign
            ex_pkg::ALU_SRA: res_o = $unsigned($signed(op1_i) >>> shamt);
            default: begin
                // Compares put their outcome in bit 0 with zeros above
                res_o = {{(WIDTH-1){1'b0}}, cmp};
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/id_ex_regs.sv */
`timescale 1ns/10ps
`default_nettype none

// ID to EX pipeline registers
module id_ex_regs (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            stall_i,
    input  wire logic            flush_i,
    input  wire ex_pkg::ex_ctrl_t id_ctrl_i,
    input  wire ex_pkg::ex_data_t id_data_i,
    output ex_pkg::ex_ctrl_t     ex_ctrl_o,
    output ex_pkg::ex_data_t     ex_data_o,
    output ex_pkg::csr_req_t     csr_req_o,
    output logic                 csr_first_cycle_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline conditions
    ////////////////////////////////////////////////////////////////////////////

    logic             advance;
    logic             bubble;
    logic             capture;
    logic             csr_capture;
    ex_pkg::csr_req_t csr_req_in;
    logic             first_cycle;

    // Stall freezes everything
    assign advance     = !stall_i;
    // Flush only acts on an unstalled edge
    assign bubble      = advance && flush_i;
    assign capture     = advance && !flush_i;
    // CSR request only moves for real CSR accesses
    assign csr_capture = capture && id_ctrl_i.csr_access;

    // wdata rides on operand 1, address on the low bits of operand 2
    assign csr_req_in.addr  = id_data_i.operand_2[ex_pkg::CSR_ADDR_W-1:0];
    assign csr_req_in.wdata = id_data_i.operand_1;

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    // Control, loads a bubble on flush
    stage_reg #(
        .payload_t   (ex_pkg::ex_ctrl_t),
        .RESET_VALUE (ex_pkg::EX_CTRL_IDLE)
    ) ctrl_reg (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .load_i        (capture),
        .clear_i       (bubble),
        .clear_value_i (ex_pkg::EX_CTRL_IDLE),
        .d_i           (id_ctrl_i),
        .q_o           (ex_ctrl_o)
    );

    // Data holds through a flush
    stage_reg #(
        .payload_t   (ex_pkg::ex_data_t),
        .RESET_VALUE (ex_pkg::ex_data_t'('0))
    ) data_reg (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .load_i        (capture),
        .clear_i       (1'b0),
        .clear_value_i (ex_pkg::ex_data_t'('0)),
        .d_i           (id_data_i),
        .q_o           (ex_data_o)
    );

    stage_reg #(
        .payload_t   (ex_pkg::csr_req_t),
        .RESET_VALUE (ex_pkg::csr_req_t'('0))
    ) csr_reg (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .load_i        (csr_capture),
        .clear_i       (1'b0),
        .clear_value_i (ex_pkg::csr_req_t'('0)),
        .d_i           (csr_req_in),
        .q_o           (csr_req_o)
    );

    // First cycle of a CSR access, rdata is fresh only here
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            first_cycle <= 1'b0;
        end else if (stall_i) begin
            first_cycle <= 1'b0;
        end else begin
            first_cycle <= id_ctrl_i.csr_access;
        end
    end

    assign csr_first_cycle_o = first_cycle;

endmodule

`default_nettype wire

/* hw/stage_reg.sv */
`timescale 1ns/10ps
`default_nettype none

// Pipeline register for an arbitrary payload
module stage_reg #(
    parameter type      payload_t   = logic,
    parameter payload_t RESET_VALUE = '0
) (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     load_i,
    input  wire logic     clear_i,
    input  wire payload_t clear_value_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    payload_t q;

    // Clear wins over load, otherwise hold
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q <= RESET_VALUE;
        end else if (clear_i) begin
            q <= clear_value_i;
        end else if (load_i) begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

`default_nettype wire

/* hw/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Data path width for operands, PC and results
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    // CSR address comes from the low bits of operand 2
    localparam int CSR_ADDR_W = 12;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        // Branch compares, result in bit 0
        ALU_EQ   = 4'd10,
        ALU_NE   = 4'd11,
        ALU_LT   = 4'd12,
        ALU_GE   = 4'd13,
        ALU_GEU  = 4'd14
    } alu_op_t;

    // Destination bank, only forwarded to MEM
    typedef enum logic {
        X_REG = 1'b0,
        F_REG = 1'b1
    } reg_bank_t;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } data_type_t;

    // Next PC selection, forwarded to fetch
    typedef enum logic [1:0] {
        PC_NEXT   = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JUMP   = 2'd2,
        PC_TRAP   = 2'd3
    } pc_source_t;

    typedef enum logic [1:0] {
        CSR_READ  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////////////////////////////////////////

    // Control fields of one instruction in EX
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd_addr;
        reg_bank_t             rd_bank;
        logic                  mem_req;
        logic                  mem_wen;
        data_type_t            mem_type;
        logic                  mem_sext;
        logic                  reg_alu_wen;
        logic                  reg_mem_wen;
        pc_source_t            pc_source;
        logic                  is_branch;
        logic                  csr_access;
        csr_op_t               csr_op;
        logic                  valid;
    } ex_ctrl_t;

    // Bubble, nothing enabled and nothing valid
    localparam ex_ctrl_t EX_CTRL_IDLE = '{
        rd_addr:     '0,
        rd_bank:     X_REG,
        mem_req:     1'b0,
        mem_wen:     1'b0,
        mem_type:    WORD,
        mem_sext:    1'b0,
        reg_alu_wen: 1'b0,
        reg_mem_wen: 1'b0,
        pc_source:   PC_NEXT,
        is_branch:   1'b0,
        csr_access:  1'b0,
        csr_op:      CSR_READ,
        valid:       1'b0
    };

    // Data fields, 164 bits
    typedef struct packed {
        alu_op_t         alu_op;
        logic [XLEN-1:0] operand_1;
        logic [XLEN-1:0] operand_2;
        logic [XLEN-1:0] mem_wdata;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] branch_target;
    } ex_data_t;

    // CSR request, 44 bits
    typedef struct packed {
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } csr_req_t;

    // Bundle handed to the memory stage
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd_addr;
        reg_bank_t             rd_bank;
        logic [XLEN-1:0]       result;
        logic                  mem_req;
        logic                  mem_wen;
        data_type_t            mem_type;
        logic                  mem_sext;
        logic [XLEN-1:0]       mem_wdata;
        logic                  reg_alu_wen;
        logic                  reg_mem_wen;
        logic                  valid;
    } ex_mem_t;

endpackage

`default_nettype wire
